// ==== sources.f ====
snes_cart_pkg.sv
cart_header_detect.sv
cheat_code_loader.sv
ram_clear.sv
backup_sync.sv
cart_loader_top.sv
tb_cart_loader.sv

// ==== Makefile ====
SOURCES = $(wildcard *.sv)

obj_dir/Vtb_cart_loader: sources.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_cart_loader -f sources.f

run: obj_dir/Vtb_cart_loader
	./obj_dir/Vtb_cart_loader | tee sim.log
	grep -q 'All tests passed!' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== tb_cart_loader.sv ====
// Testbench for the cartridge loader: random stimulus, reference model, storage model, checks
`timescale 1ns/10ps

module tb_cart_loader;

	localparam int N_IMAGES        = 20;
	localparam int IMAGE_WORDS     = 8;
	localparam int N_CHEATS        = 8;
	localparam int N_XFERS         = 4;
	localparam int MAX_SECTORS     = 16;
	localparam int CLEAR_CYCLES    = 1024;
	localparam int WATCHDOG_CYCLES = 4 * (16 + N_IMAGES * IMAGE_WORDS * 4 + N_CHEATS * 8 * 4 +
		(N_IMAGES + 1) * CLEAR_CYCLES + N_XFERS * MAX_SECTORS * 16);

	logic clk_sys = 1'b0;
	logic reset;
	logic ioctl_download, ioctl_wr;
	logic [7:0] ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [2:0] lhrom_type;
	logic [1:0] region_sel, wram_init;
	logic bk_load, bk_save, autosave, osd_status, bsram_write;
	logic img_mounted, img_readonly, img_size_nz, sd_ack;
	logic [7:0] rom_type;
	logic [23:0] rom_mask, ram_mask;
	logic pal, gg_valid, clearing;
	snes_cart_pkg::cheat_code_t gg_code;
	logic [9:0] fill_addr;
	logic [7:0] wram_fill_data;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr, bk_busy, bk_loading, bk_pending, bk_ena, led;

	// Reference model state
	int clear_left;
	logic valid_due, cart_seen, cart_now;
	logic [2:0] m_map;
	logic [3:0] m_rom_size = 4'd0;
	logic [3:0] m_ram_size = 4'd0;
	logic [7:0] m_rom_type = 8'd0;
	logic m_region = 1'b0;
	logic [31:0] req_lba[$];
	logic req_wr[$];
	int ack_delay, ack_hold;

	cart_loader_top #(
		.FILL_ADDR_BITS(10)
	) cart_loader_top_i (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.ioctl_wr(ioctl_wr), .lhrom_type(lhrom_type), .region_sel(region_sel),
		.wram_init(wram_init), .bk_load(bk_load), .bk_save(bk_save), .autosave(autosave),
		.osd_status(osd_status), .bsram_write(bsram_write), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size_nz(img_size_nz), .sd_ack(sd_ack),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal),
		.gg_code(gg_code), .gg_valid(gg_valid), .clearing(clearing), .fill_addr(fill_addr),
		.wram_fill_data(wram_fill_data), .sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_busy(bk_busy), .bk_loading(bk_loading), .bk_pending(bk_pending),
		.bk_ena(bk_ena), .led(led)
	);

	always #50 clk_sys = ~clk_sys;

	task automatic check_equal(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %0h, expected %0h", name, got, exp);
			$display("Test failures found");
			$fatal(1);
		end
	endtask

	function automatic logic [23:0] rom_mask_of(input logic [3:0] size);
		logic [23:0] m;
		m = snes_cart_pkg::SIZE_UNIT << size;
		return m - 24'd1;
	endfunction

	function automatic logic [23:0] ram_mask_of(input logic [3:0] size);
		return (size == 4'd0) ? 24'd0 : rom_mask_of(size);
	endfunction

	function automatic logic [7:0] fill_pattern(input logic [1:0] sel, input logic [9:0] a);
		case (sel)
			2'd0: return (a[8] != a[2]) ? 8'h66 : 8'h99;
			2'd1: return (a[9] != a[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	// ==================================================
	// Header model
	// ==================================================

	task automatic model_cart_write(input logic [24:0] addr, input logic [15:0] data);
		logic [24:0] size_addr;
		logic fixed;
		fixed = 1'b1;
		case (m_map)
			snes_cart_pkg::MAP_LOROM:   size_addr = snes_cart_pkg::LOROM_HDR_ADDR;
			snes_cart_pkg::MAP_HIROM:   size_addr = snes_cart_pkg::HIROM_HDR_ADDR;
			snes_cart_pkg::MAP_EXHIROM: size_addr = snes_cart_pkg::EXHIROM_HDR_ADDR;
			default: begin
				size_addr = 25'd0;
				fixed = 1'b0;
			end
		endcase
		if (addr == 25'd0) begin
			m_rom_size = snes_cart_pkg::DEFAULT_ROM_SIZE;
			m_ram_size = 4'd0;
			if (m_map == snes_cart_pkg::MAP_AUTO && data[7:0] != 8'd0) begin
				m_rom_size = data[3:0];
				m_ram_size = data[7:4];
			end
			if (m_map == snes_cart_pkg::MAP_HIROM)
				m_rom_type = 8'd1;
			else if (m_map == snes_cart_pkg::MAP_EXHIROM)
				m_rom_type = 8'd2;
			else if (m_map == snes_cart_pkg::MAP_AUTO)
				m_rom_type = data[15:8];
			else
				m_rom_type = 8'd0;
		end
		if (addr == 25'd2)
			m_region = data[8];
		if (fixed && addr == size_addr)
			m_rom_size = data[11:8];
		if (fixed && addr == size_addr + 25'd2)
			m_ram_size = data[3:0];
	endtask

	task automatic write_word(input logic [24:0] addr, input logic [15:0] data);
		int gap;
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		gap = $urandom_range(0, 2);
		repeat (gap) @(posedge clk_sys);
	endtask

	// Sparse image: first words plus the size words of every mapping
	task automatic run_image(input logic [2:0] map, input logic [1:0] rsel,
		input logic [15:0] w0);
		logic [24:0] addr_list [0:7];
		logic [15:0] data;
		logic [7:0] idx;
		addr_list = '{25'd0, 25'd2,
			snes_cart_pkg::LOROM_HDR_ADDR, snes_cart_pkg::LOROM_HDR_ADDR + 25'd2,
			snes_cart_pkg::HIROM_HDR_ADDR, snes_cart_pkg::HIROM_HDR_ADDR + 25'd2,
			snes_cart_pkg::EXHIROM_HDR_ADDR, snes_cart_pkg::EXHIROM_HDR_ADDR + 25'd2};
		idx = 8'($urandom);
		idx[5:0] = snes_cart_pkg::INDEX_CART[5:0];
		m_map = map;
		@(posedge clk_sys);
		lhrom_type     <= map;
		region_sel     <= rsel;
		wram_init      <= 2'($urandom_range(0, 3));
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		for (int i = 0; i < IMAGE_WORDS; i++) begin
			data = (i == 0) ? w0 : 16'($urandom);
			model_cart_write(addr_list[i], data);
			write_word(addr_list[i], data);
		end
		// Download activity lights the LED
		@(negedge clk_sys);
		check_equal("led", led, 1'b1);
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_equal("rom_type", rom_type, m_rom_type);
		check_equal("rom_mask", rom_mask, rom_mask_of(m_rom_size));
		check_equal("ram_mask", ram_mask, ram_mask_of(m_ram_size));
		check_equal("pal", pal, (rsel == 2'd0) ? m_region : (rsel == 2'd2));
	endtask

	task automatic run_cheat();
		logic [15:0] w [0:7];
		@(posedge clk_sys);
		ioctl_index    <= snes_cart_pkg::INDEX_CHEAT;
		ioctl_download <= 1'b1;
		for (int i = 0; i < 8; i++) begin
			w[i] = 16'($urandom);
			write_word(25'(i * 2), w[i]);
		end
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		@(negedge clk_sys);
		check_equal("gg_code.flags", gg_code.fields.flags, {w[1], w[0]});
		check_equal("gg_code.address", gg_code.fields.address, {w[3], w[2]});
		check_equal("gg_code.compare", gg_code.fields.compare, {w[5], w[4]});
		check_equal("gg_code.replace", gg_code.fields.replace, {w[7], w[6]});
	endtask

	// ==================================================
	// Backup transfers
	// ==================================================

	task automatic request_pulse(input int which);
		@(posedge clk_sys);
		case (which)
			0: bsram_write <= 1'b1;
			1: bk_save <= 1'b1;
			default: bk_load <= 1'b1;
		endcase
		@(posedge clk_sys);
		bsram_write <= 1'b0;
		bk_save     <= 1'b0;
		bk_load     <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic wait_transfer(input logic exp_load);
		int last;
		last = int'(ram_mask_of(m_ram_size) >> snes_cart_pkg::SECTOR_SHIFT);
		check_equal("bk_busy", bk_busy, 1'b1);
		while (bk_busy) begin
			check_equal("bk_loading", bk_loading, exp_load);
			@(negedge clk_sys);
		end
		check_equal("bk_loading", bk_loading, 1'b0);
		check_equal("bk_pending", bk_pending, 1'b0);
		check_equal("sector count", req_lba.size(), last + 1);
		for (int i = 0; i < req_lba.size(); i++) begin
			check_equal("sd_lba", req_lba[i], i);
			check_equal("sd_wr", req_wr[i], !exp_load);
		end
		req_lba.delete();
		req_wr.delete();
	endtask

	// Storage side answers each sector request
	initial begin
		forever begin
			@(negedge clk_sys);
			if (!reset && (sd_rd || sd_wr)) begin
				req_lba.push_back(sd_lba);
				req_wr.push_back(sd_wr);
				ack_delay = $urandom_range(1, 8);
				repeat (ack_delay) @(posedge clk_sys);
				sd_ack <= 1'b1;
				ack_hold = $urandom_range(1, 4);
				repeat (ack_hold) @(posedge clk_sys);
				sd_ack <= 1'b0;
			end
		end
	end

	// Cycle checks of the clear sweep and the cheat strobe
	always @(negedge clk_sys) begin
		if (reset) begin
			clear_left = 0;
			valid_due  = 1'b0;
			cart_seen  = 1'b0;
		end else begin
			check_equal("clearing", clearing, clear_left != 0);
			if (clear_left != 0) begin
				check_equal("fill_addr", fill_addr, CLEAR_CYCLES - clear_left);
				check_equal("wram_fill_data", wram_fill_data,
					fill_pattern(wram_init, 10'(CLEAR_CYCLES - clear_left)));
				clear_left--;
			end
			check_equal("gg_valid", gg_valid, valid_due);
			valid_due = ioctl_download && ioctl_index == 8'hFF && ioctl_wr &&
				!ioctl_addr[0] && ioctl_addr[3:1] == 3'd7;
			cart_now = ioctl_download && ioctl_index[5:0] == snes_cart_pkg::INDEX_CART[5:0];
			if (cart_now && !cart_seen)
				clear_left = CLEAR_CYCLES;
			cart_seen = cart_now;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Test failures found");
		$fatal(1);
	end

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin
		logic [15:0] w0;
		reset = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = 25'd0;
		ioctl_dout = 16'd0;
		lhrom_type = 3'd0;
		region_sel = 2'd0;
		wram_init = 2'd0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		autosave = 1'b0;
		osd_status = 1'b0;
		bsram_write = 1'b0;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		sd_ack = 1'b0;
		void'($urandom(32'hda9e));
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
		@(negedge clk_sys);

		for (int n = 0; n < N_IMAGES; n++) begin
			w0 = 16'($urandom);
			if ($urandom_range(0, 3) == 0)
				w0[7:0] = 8'd0;
			run_image(3'($urandom_range(0, 4)), 2'($urandom_range(0, 2)), w0);
			while (clearing) @(negedge clk_sys);
		end

		for (int n = 0; n < N_CHEATS; n++)
			run_cheat();

		// Writable save image, download ends with an automatic load
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		img_size_nz <= 1'b1;
		run_image(snes_cart_pkg::MAP_AUTO, 2'd0, {8'h01, 4'($urandom_range(1, 3)), 4'h8});
		check_equal("bk_ena", bk_ena, 1'b1);
		wait_transfer(1'b1);
		while (clearing) @(negedge clk_sys);

		request_pulse(0);
		check_equal("bk_pending", bk_pending, 1'b1);
		check_equal("led", led, 1'b0);
		request_pulse(1);
		wait_transfer(1'b0);
		request_pulse(2);
		wait_transfer(1'b1);

		// Autosave once the menu opens
		@(posedge clk_sys);
		autosave <= 1'b1;
		request_pulse(0);
		check_equal("led", led, 1'b1);
		@(posedge clk_sys);
		osd_status <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		wait_transfer(1'b0);

		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== cart_loader_top.sv ====
// Cartridge loading front end: download decode and unit interconnect
`timescale 1ns/10ps

module cart_loader_top #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic [24:0]                ioctl_addr,
	input  logic [15:0]                ioctl_dout,
	input  logic                       ioctl_wr,
	input  logic [2:0]                 lhrom_type,
	input  logic [1:0]                 region_sel,
	input  logic [1:0]                 wram_init,
	input  logic                       bk_load,
	input  logic                       bk_save,
	input  logic                       autosave,
	input  logic                       osd_status,
	input  logic                       bsram_write,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic                       img_size_nz,
	input  logic                       sd_ack,
	output logic [7:0]                 rom_type,
	output logic [23:0]                rom_mask,
	output logic [23:0]                ram_mask,
	output logic                       pal,
	output snes_cart_pkg::cheat_code_t gg_code,
	output logic                       gg_valid,
	output logic                       clearing,
	output logic [FILL_ADDR_BITS-1:0]  fill_addr,
	output logic [7:0]                 wram_fill_data,
	output logic [31:0]                sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	output logic                       bk_busy,
	output logic                       bk_loading,
	output logic                       bk_pending,
	output logic                       bk_ena,
	output logic                       led
);

	logic cart_download;
	logic code_download;
	logic download_start;
	logic old_cart_download;

	// ==================================================
	// Download kind
	// ==================================================

	assign cart_download = ioctl_download &&
		ioctl_index[5:0] == snes_cart_pkg::INDEX_CART[5:0];
	assign code_download = ioctl_download && ioctl_index == snes_cart_pkg::INDEX_CHEAT;

	always_ff @(posedge clk_sys) begin
		if (reset)
			old_cart_download <= 1'b0;
		else
			old_cart_download <= cart_download;
	end

	assign download_start = cart_download & ~old_cart_download;

	// Activity or an unsaved backup
	assign led = cart_download | (autosave & bk_pending);

	cart_header_detect cart_header_detect_i (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.lhrom_type(lhrom_type), .region_sel(region_sel),
		.rom_type(rom_type), .rom_mask(rom_mask), .ram_mask(ram_mask), .pal(pal)
	);

	cheat_code_loader cheat_code_loader_i (
		.clk_sys(clk_sys), .reset(reset), .code_download(code_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr[3:0]), .ioctl_dout(ioctl_dout),
		.gg_code(gg_code), .gg_valid(gg_valid)
	);

	ram_clear #(
		.FILL_ADDR_BITS(FILL_ADDR_BITS)
	) ram_clear_i (
		.clk_sys(clk_sys), .reset(reset), .download_start(download_start),
		.wram_init(wram_init), .clearing(clearing), .fill_addr(fill_addr),
		.wram_fill_data(wram_fill_data)
	);

	backup_sync backup_sync_i (
		.clk_sys(clk_sys), .reset(reset), .cart_download(cart_download),
		.download_start(download_start), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size_nz(img_size_nz), .ram_mask(ram_mask),
		.bk_load(bk_load), .bk_save(bk_save), .autosave(autosave),
		.osd_status(osd_status), .bsram_write(bsram_write), .sd_ack(sd_ack),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .bk_busy(bk_busy),
		.bk_loading(bk_loading), .bk_pending(bk_pending), .bk_ena(bk_ena)
	);

endmodule

// ==== backup_sync.sv ====
// Backup RAM enable, pending write tracking and sector transfer sequencer
`timescale 1ns/10ps

module backup_sync (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        download_start,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_size_nz,
	input  logic [23:0] ram_mask,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        autosave,
	input  logic        osd_status,
	input  logic        bsram_write,
	input  logic        sd_ack,
	output logic [31:0] sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_loading,
	output logic        bk_pending,
	output logic        bk_ena
);

	logic        old_download;
	logic        old_load;
	logic        old_save;
	logic        old_ack;
	logic        load_req;
	logic        save_req;
	logic        auto_load;
	logic [31:0] last_lba;

	// Autosave fires once the menu is open
	assign load_req  = bk_load & bk_ena;
	assign save_req  = (bk_save | (bk_pending & osd_status & autosave)) & bk_ena;
	assign auto_load = old_download & ~cart_download & img_size_nz & bk_ena;
	assign last_lba  = {8'd0, ram_mask} >> snes_cart_pkg::SECTOR_SHIFT;

	// ==================================================
	// Enable and pending flags
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
			bk_pending   <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (download_start)
				bk_ena <= 1'b0;
			// Save file is mounted before the download ends
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;
			if (bk_ena && !osd_status && bsram_write)
				bk_pending <= 1'b1;
			else if (bk_busy || !bk_ena)
				bk_pending <= 1'b0;
		end
	end

	// ==================================================
	// Sector sequencer
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= 32'd0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= load_req;
			old_save <= save_req;
			old_ack  <= sd_ack;
			if (sd_ack && !old_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end
			if (!bk_busy) begin
				if ((load_req && !old_load) || (save_req && !old_save) || auto_load) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_req | auto_load;
					sd_lba     <= 32'd0;
					sd_rd      <= load_req | auto_load;
					sd_wr      <= ~(load_req | auto_load);
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 32'd1;
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	a_rd_wr_excl : assert property (
		@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr)
	);

endmodule

// ==== ram_clear.sv ====
// Memory clear sweep with work RAM power-up pattern
`timescale 1ns/10ps

module ram_clear #(
	parameter int FILL_ADDR_BITS = 17
) (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      download_start,
	input  logic [1:0]                wram_init,
	output logic                      clearing,
	output logic [FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                wram_fill_data
);

	// ==================================================
	// Sweep counter
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			if (download_start) begin
				clearing  <= 1'b1;
				fill_addr <= '0;
			end else begin
				// One pass over the whole range
				if (&fill_addr)
					clearing <= 1'b0;
				if (clearing)
					fill_addr <= fill_addr + 1'b1;
				else
					fill_addr <= '0;
			end
		end
	end

	// ==================================================
	// Fill pattern
	// ==================================================

	always_comb begin
		case (wram_init)
			snes_cart_pkg::WRAM_INIT_9966:
				wram_fill_data = (fill_addr[8] ^ fill_addr[2]) ?
					snes_cart_pkg::FILL_66 : snes_cart_pkg::FILL_99;
			snes_cart_pkg::WRAM_INIT_00FF:
				wram_fill_data = (fill_addr[9] ^ fill_addr[0]) ?
					snes_cart_pkg::FILL_FF : snes_cart_pkg::FILL_00;
			snes_cart_pkg::WRAM_INIT_55:
				wram_fill_data = snes_cart_pkg::FILL_55;
			default:
				wram_fill_data = snes_cart_pkg::FILL_FF;
		endcase
	end

	a_idle_addr_zero : assert property (
		@(posedge clk_sys) disable iff (reset)
		!clearing |-> fill_addr == '0
	);

endmodule

// ==== cheat_code_loader.sv ====
// Cheat file word collector and cheat code strobe
`timescale 1ns/10ps

module cheat_code_loader (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      code_download,
	input  logic                      ioctl_wr,
	input  logic [3:0]                ioctl_addr,
	input  logic [15:0]               ioctl_dout,
	output snes_cart_pkg::cheat_code_t gg_code,
	output logic                      gg_valid
);

	logic       code_wr;
	logic [2:0] word_pos;

	// Words sit on even byte addresses
	assign code_wr  = code_download & ioctl_wr & ~ioctl_addr[0];
	assign word_pos = ioctl_addr[3:1];

	always_ff @(posedge clk_sys) begin
		if (code_wr)
			gg_code.words[snes_cart_pkg::CHEAT_SLOT[word_pos]] <= ioctl_dout;
	end

	// Last word of a code completes it
	always_ff @(posedge clk_sys) begin
		if (reset)
			gg_valid <= 1'b0;
		else
			gg_valid <= code_wr && word_pos == 3'd7;
	end

	a_valid_single : assert property (
		@(posedge clk_sys) disable iff (reset)
		gg_valid |=> !gg_valid
	);

endmodule

// ==== cart_header_detect.sv ====
// Cartridge header decoder: mapping type, ROM and RAM size masks, video region
`timescale 1ns/10ps

module cart_header_detect (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_download,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [15:0] ioctl_dout,
	input  logic [2:0]  lhrom_type,
	input  logic [1:0]  region_sel,
	output logic [7:0]  rom_type,
	output logic [23:0] rom_mask,
	output logic [23:0] ram_mask,
	output logic        pal
);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic        rom_region;
	logic [3:0]  rom_size_nx;
	logic [3:0]  ram_size_nx;
	logic [7:0]  rom_type_nx;
	logic [24:0] size_addr;
	logic        size_fixed;

	// Where a fixed mapping keeps its size bytes
	always_comb begin
		size_fixed = 1'b1;
		case (lhrom_type)
			snes_cart_pkg::MAP_LOROM:   size_addr = snes_cart_pkg::LOROM_HDR_ADDR;
			snes_cart_pkg::MAP_HIROM:   size_addr = snes_cart_pkg::HIROM_HDR_ADDR;
			snes_cart_pkg::MAP_EXHIROM: size_addr = snes_cart_pkg::EXHIROM_HDR_ADDR;
			default: begin
				size_addr  = 25'd0;
				size_fixed = 1'b0;
			end
		endcase
	end

	always_comb begin
		rom_size_nx = rom_size;
		ram_size_nx = ram_size;
		rom_type_nx = rom_type;
		if (ioctl_addr == 25'd0) begin
			rom_size_nx = snes_cart_pkg::DEFAULT_ROM_SIZE;
			ram_size_nx = 4'd0;
			// Loader puts packed sizes in the first byte
			if (lhrom_type == snes_cart_pkg::MAP_AUTO && ioctl_dout[7:0] != 8'd0)
				{ram_size_nx, rom_size_nx} = ioctl_dout[7:0];
			case (lhrom_type)
				snes_cart_pkg::MAP_NO_HEADER,
				snes_cart_pkg::MAP_LOROM:   rom_type_nx = 8'd0;
				snes_cart_pkg::MAP_HIROM:   rom_type_nx = 8'd1;
				snes_cart_pkg::MAP_EXHIROM: rom_type_nx = 8'd2;
				default:                    rom_type_nx = ioctl_dout[15:8];
			endcase
		end
		if (size_fixed && ioctl_addr == size_addr)
			rom_size_nx = ioctl_dout[11:8];
		if (size_fixed && ioctl_addr == size_addr + 25'd2)
			ram_size_nx = ioctl_dout[3:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= 4'd0;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			rom_type   <= 8'd0;
			rom_mask   <= 24'd0;
			ram_mask   <= 24'd0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				rom_size <= rom_size_nx;
				ram_size <= ram_size_nx;
				rom_type <= rom_type_nx;
				if (ioctl_addr == 25'd2)
					rom_region <= ioctl_dout[8];
				// Masks follow the new sizes right away
				rom_mask <= (snes_cart_pkg::SIZE_UNIT << rom_size_nx) - 24'd1;
				ram_mask <= (ram_size_nx != 4'd0) ?
					(snes_cart_pkg::SIZE_UNIT << ram_size_nx) - 24'd1 : 24'd0;
			end
		end else begin
			// 0 auto, 1 NTSC, 2 PAL
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

// ==== snes_cart_pkg.sv ====
// Cartridge loader constants: header offsets, mapping codes, fill patterns, cheat code layout
package snes_cart_pkg;

	// ==================================================
	// Cartridge stream layout
	// ==================================================

	// Copier header in front of the image
	localparam logic [24:0] HEADER_SKIP = 25'h200;

	// Stream address of the ROM size word, RAM size follows two bytes later
	localparam logic [24:0] LOROM_HDR_ADDR   = 25'h007FD6 + HEADER_SKIP;
	localparam logic [24:0] HIROM_HDR_ADDR   = 25'h00FFD6 + HEADER_SKIP;
	localparam logic [24:0] EXHIROM_HDR_ADDR = 25'h40FFD6 + HEADER_SKIP;

	// Mapping override from the menu
	localparam logic [2:0] MAP_AUTO      = 3'd0;
	localparam logic [2:0] MAP_NO_HEADER = 3'd1;
	localparam logic [2:0] MAP_LOROM     = 3'd2;
	localparam logic [2:0] MAP_HIROM     = 3'd3;
	localparam logic [2:0] MAP_EXHIROM   = 3'd4;

	// Download index values
	localparam logic [7:0] INDEX_CART  = 8'h00;
	localparam logic [7:0] INDEX_CHEAT = 8'hFF;

	// One size code step doubles this many bytes
	localparam logic [23:0] SIZE_UNIT        = 24'd1024;
	localparam logic [3:0]  DEFAULT_ROM_SIZE = 4'd12;

	// 512 byte sectors on the storage side
	localparam int unsigned SECTOR_SHIFT = 9;

	// ==================================================
	// Work RAM power-up patterns
	// ==================================================

	localparam logic [1:0] WRAM_INIT_9966 = 2'd0;
	localparam logic [1:0] WRAM_INIT_00FF = 2'd1;
	localparam logic [1:0] WRAM_INIT_55   = 2'd2;
	localparam logic [1:0] WRAM_INIT_FF   = 2'd3;

	localparam logic [7:0] FILL_99 = 8'h99;
	localparam logic [7:0] FILL_66 = 8'h66;
	localparam logic [7:0] FILL_00 = 8'h00;
	localparam logic [7:0] FILL_FF = 8'hFF;
	localparam logic [7:0] FILL_55 = 8'h55;

	// ==================================================
	// Cheat code
	// ==================================================

	// Same 128 bits seen as file word slots or as code fields
	typedef union packed {
		logic [7:0][15:0] words;
		struct packed {
			logic [31:0] flags;
			logic [31:0] address;
			logic [31:0] compare;
			logic [31:0] replace;
		} fields;
	} cheat_code_t;

	// Slot for each file word position, low word of each field first
	localparam logic [7:0][2:0] CHEAT_SLOT = {
		3'd1, 3'd0, 3'd3, 3'd2, 3'd5, 3'd4, 3'd7, 3'd6
	};

endpackage
